// ==== rtl/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ======================================================================
// Memory map
// ======================================================================

// Address bits 31:28 select the slave
`define SOC_RAM_BASE_NIB   4'h8
`define SOC_CLINT_BASE_NIB 4'h3

// ======================================================================
// Main RAM geometry and timing
// ======================================================================

// Depth in 32-bit words
`define SOC_RAM_WORDS   1024
// Read latency in cycles, two or more
`define SOC_RAM_LATENCY 4
// Words per cache line
`define SOC_LINE_WORDS  4

// CLINT register offsets, low word; high word at offset + 4
`define SOC_CLINT_MSIP_OFS     16'h0000
`define SOC_CLINT_MTIMECMP_OFS 16'h4000
`define SOC_CLINT_MTIME_OFS    16'hBFF8

`endif

// ==== rtl/soc_pkg.sv ====
`include "soc_consts.svh"

package soc_pkg;

  // Bus fields
  typedef logic [31:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  wb_sel_t;

  // Wishbone B4 cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // Cache line and its addressing
  typedef logic [32*`SOC_LINE_WORDS-1:0] line_t;
  typedef logic [$clog2(`SOC_RAM_WORDS/`SOC_LINE_WORDS)-1:0] line_idx_t;
  typedef logic [1:0] word_ofs_t;

  // CLINT timer width
  typedef logic [63:0] mtime_t;

  // RAM slave FSM
  typedef enum logic [1:0] {RAM_IDLE, RAM_FETCH, RAM_LINE_READY} ram_state_e;

endpackage

// ==== rtl/wb_if.sv ====
`timescale 1ns/100ps

// Wishbone B4 classic bus, no stall or retry
interface wb_if
  import soc_pkg::*;
();

  // Request side
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_sel_t  sel;
  wb_cti_e  cti;

  // Response side
  wb_data_t dat_r;
  logic     ack;
  logic     err;

  modport master (output cyc, stb, we, adr, dat_w, sel, cti, input dat_r, ack, err);

  // Mirror of master
  modport slave (input cyc, stb, we, adr, dat_w, sel, cti, output dat_r, ack, err);

endinterface

// ==== rtl/wb_interconnect.sv ====
`timescale 1ns/100ps
`include "soc_consts.svh"

// One master to two slaves, purely combinational
module wb_interconnect
  import soc_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  m_bus,
  wb_if.master ram_bus,
  wb_if.master clint_bus
);

  logic     req;
  logic     sel_ram;
  logic     sel_clint;
  wb_data_t resp_dat;

  // Decode on the top address nibble
  assign req       = m_bus.cyc & m_bus.stb;
  assign sel_ram   = (m_bus.adr[31:28] == `SOC_RAM_BASE_NIB);
  assign sel_clint = (m_bus.adr[31:28] == `SOC_CLINT_BASE_NIB);

  // Only the selected slave sees cyc and stb
  assign ram_bus.cyc   = m_bus.cyc & sel_ram;
  assign ram_bus.stb   = m_bus.stb & sel_ram;
  assign clint_bus.cyc = m_bus.cyc & sel_clint;
  assign clint_bus.stb = m_bus.stb & sel_clint;

  // Remaining request fields broadcast
  assign ram_bus.we      = m_bus.we;
  assign ram_bus.adr     = m_bus.adr;
  assign ram_bus.dat_w   = m_bus.dat_w;
  assign ram_bus.sel     = m_bus.sel;
  assign ram_bus.cti     = m_bus.cti;
  assign clint_bus.we    = m_bus.we;
  assign clint_bus.adr   = m_bus.adr;
  assign clint_bus.dat_w = m_bus.dat_w;
  assign clint_bus.sel   = m_bus.sel;
  assign clint_bus.cti   = m_bus.cti;

  // Read data back from the selected slave, zero otherwise
  always_comb begin
    resp_dat = '0;
    if (sel_ram) begin
      resp_dat = ram_bus.dat_r;
    end else if (sel_clint) begin
      resp_dat = clint_bus.dat_r;
    end
  end

  assign m_bus.dat_r = resp_dat;
  assign m_bus.ack   = (sel_ram & ram_bus.ack) | (sel_clint & clint_bus.ack);
  // Unmapped nibble errors in the same cycle
  assign m_bus.err   = (req & ~sel_ram & ~sel_clint)
                     | (sel_ram & ram_bus.err) | (sel_clint & clint_bus.err);

endmodule

// ==== rtl/wb_ram_slave.sv ====
`timescale 1ns/100ps
`include "soc_consts.svh"

// Cache-line RAM behind a Wishbone slave port
module wb_ram_slave
  import soc_pkg::*;
(
  input logic clk_i,
  input logic rst_ni,
  wb_if.slave bus
);

  localparam int LAT    = `SOC_RAM_LATENCY;
  localparam int LINES  = `SOC_RAM_WORDS / `SOC_LINE_WORDS;
  localparam int IDX_W  = $bits(line_idx_t);
  localparam int STRB_W = 4 * `SOC_LINE_WORDS;

  // ======================================================================
  // Storage and state
  // ======================================================================

  line_t             mem [LINES];
  // Fetched line, also the burst buffer
  line_t             line_q;
  ram_state_e        state_q;
  // One bit travels through per read
  logic [LAT-1:0]    lat_q;

  logic              req;
  logic              wr_req;
  logic              rd_start;
  logic              rd_beat;
  line_idx_t         line_idx;
  word_ofs_t         word_ofs;
  line_t             wr_line;
  logic [STRB_W-1:0] wr_strb;

  assign req      = bus.cyc & bus.stb;
  assign wr_req   = req & bus.we;
  // New fetch only from idle
  assign rd_start = req & ~bus.we & (state_q == RAM_IDLE);
  // Later burst beat, served from the buffer
  assign rd_beat  = req & ~bus.we & (state_q == RAM_LINE_READY);

  // Byte address to line index and word position
  assign line_idx = bus.adr[IDX_W+3:4];
  assign word_ofs = bus.adr[3:2];

  // ======================================================================
  // Write strobe expansion
  // ======================================================================

  always_comb begin
    // Same word in every slot of the line
    wr_line = {`SOC_LINE_WORDS{bus.dat_w}};
    wr_strb = '0;
    if (wr_req) begin
      // Byte enables of the addressed word only
      wr_strb[word_ofs*4 +: 4] = bus.sel;
    end
  end

  // Line memory, byte-wide write enables
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < STRB_W; b++) begin
      if (wr_strb[b]) begin
        mem[line_idx][b*8 +: 8] <= wr_line[b*8 +: 8];
      end
    end
    // Capture line one edge before ack
    if (lat_q[LAT-2]) begin
      line_q <= mem[line_idx];
    end
  end

  // ======================================================================
  // Latency pipeline and burst FSM
  // ======================================================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= '0;
    end else begin
      lat_q <= {lat_q[LAT-2:0], rd_start};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RAM_IDLE;
    end else begin
      case (state_q)
        RAM_IDLE: begin
          if (rd_start) begin
            state_q <= RAM_FETCH;
          end
        end
        RAM_FETCH: begin
          // Keep the line only for an incrementing burst
          if (lat_q[LAT-1]) begin
            state_q <= (bus.cti == CTI_INCR) ? RAM_LINE_READY : RAM_IDLE;
          end
        end
        RAM_LINE_READY: begin
          // Burst over at end-of-burst or when the master leaves
          if (!bus.cyc || (rd_beat && bus.cti != CTI_INCR)) begin
            state_q <= RAM_IDLE;
          end
        end
        default: state_q <= RAM_IDLE;
      endcase
    end
  end

  // ======================================================================
  // Response
  // ======================================================================

  // Writes and buffered beats at once, fetch after the pipeline
  assign bus.ack   = wr_req | lat_q[LAT-1] | rd_beat;
  assign bus.err   = 1'b0;
  // Word extraction from the buffered line
  assign bus.dat_r = line_q[word_ofs*32 +: 32];

endmodule

// ==== rtl/wb_clint_slave.sv ====
`timescale 1ns/100ps
`include "soc_consts.svh"

// Core-local interruptor: msip, mtimecmp, mtime
module wb_clint_slave
  import soc_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  wb_if.slave  bus,
  output logic timer_irq_o,
  output logic sw_irq_o
);

  localparam logic [15:0] MSIP_OFS    = `SOC_CLINT_MSIP_OFS;
  localparam logic [15:0] CMP_LO_OFS  = `SOC_CLINT_MTIMECMP_OFS;
  localparam logic [15:0] CMP_HI_OFS  = `SOC_CLINT_MTIMECMP_OFS + 16'd4;
  localparam logic [15:0] TIME_LO_OFS = `SOC_CLINT_MTIME_OFS;
  localparam logic [15:0] TIME_HI_OFS = `SOC_CLINT_MTIME_OFS + 16'd4;

  logic        req;
  logic        first;
  logic        wr_en;
  logic [15:0] ofs;
  logic        ack_q;
  logic        msip_q;
  logic        timer_irq_q;
  mtime_t      mtimecmp_q;
  mtime_t      mtime_q;
  wb_data_t    rdata;
  wb_data_t    rdata_q;

  // Byte-select merge of a write into a register word
  function automatic wb_data_t merge_bytes(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
    wb_data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign req   = bus.cyc & bus.stb;
  // Request not yet acked
  assign first = req & ~ack_q;
  assign wr_en = first & bus.we;
  assign ofs   = bus.adr[15:0];

  // Read mux, unknown offsets read zero
  always_comb begin
    case (ofs)
      MSIP_OFS:    rdata = {31'b0, msip_q};
      CMP_LO_OFS:  rdata = mtimecmp_q[31:0];
      CMP_HI_OFS:  rdata = mtimecmp_q[63:32];
      TIME_LO_OFS: rdata = mtime_q[31:0];
      TIME_HI_OFS: rdata = mtime_q[63:32];
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
    end else begin
      // Single-cycle registered ack
      ack_q       <= first;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      // Free-running, a write to mtime overrides the increment
      mtime_q     <= mtime_q + 64'd1;
      if (wr_en) begin
        case (ofs)
          MSIP_OFS: begin
            if (bus.sel[0]) begin
              msip_q <= bus.dat_w[0];
            end
          end
          CMP_LO_OFS:  mtimecmp_q[31:0]  <= merge_bytes(mtimecmp_q[31:0], bus.dat_w, bus.sel);
          CMP_HI_OFS:  mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], bus.dat_w, bus.sel);
          TIME_LO_OFS: mtime_q[31:0]     <= merge_bytes(mtime_q[31:0], bus.dat_w, bus.sel);
          TIME_HI_OFS: mtime_q[63:32]    <= merge_bytes(mtime_q[63:32], bus.dat_w, bus.sel);
          default: ;
        endcase
      end
    end
  end

  // Read data sampled with the request
  always_ff @(posedge clk_i) begin
    if (first) begin
      rdata_q <= rdata;
    end
  end

  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;
  assign bus.dat_r   = rdata_q;
  assign sw_irq_o    = msip_q;
  assign timer_irq_o = timer_irq_q;

endmodule

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/100ps

// Wishbone slave side of the SoC: RAM and CLINT
module soc_bus_top
  import soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // External master port
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_addr_t wb_adr_i,
  input  wb_data_t wb_dat_i,
  input  wb_sel_t  wb_sel_i,
  input  wb_cti_e  wb_cti_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  output logic     wb_err_o,
  // Interrupts from the CLINT
  output logic     timer_irq_o,
  output logic     sw_irq_o
);

  wb_if m_bus ();
  wb_if ram_bus ();
  wb_if clint_bus ();

  // Plain ports onto the master bus
  assign m_bus.cyc   = wb_cyc_i;
  assign m_bus.stb   = wb_stb_i;
  assign m_bus.we    = wb_we_i;
  assign m_bus.adr   = wb_adr_i;
  assign m_bus.dat_w = wb_dat_i;
  assign m_bus.sel   = wb_sel_i;
  assign m_bus.cti   = wb_cti_i;
  assign wb_dat_o    = m_bus.dat_r;
  assign wb_ack_o    = m_bus.ack;
  assign wb_err_o    = m_bus.err;

  wb_interconnect i_interconnect (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .m_bus    (m_bus),
    .ram_bus  (ram_bus),
    .clint_bus(clint_bus)
  );

  wb_ram_slave i_ram (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .bus   (ram_bus)
  );

  wb_clint_slave i_clint (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus        (clint_bus),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

endmodule

// ==== test/tb_soc_bus.sv ====
`timescale 1ns/100ps
`include "soc_consts.svh"

module tb_soc_bus
  import soc_pkg::*;
();

  localparam int LAT       = `SOC_RAM_LATENCY;
  localparam int LINES     = `SOC_RAM_WORDS / `SOC_LINE_WORDS;
  // Cycles a slave may take before the master gives up
  localparam int ACK_LIMIT = 32;
  localparam int N_TESTS   = 6;
  // Fill pass of the RAM dominates
  localparam int TEST_CYCLES_MAX = 3 * `SOC_RAM_WORDS;
  localparam int WATCHDOG_NS     = N_TESTS * TEST_CYCLES_MAX * 40 * 2;

  logic     clk;
  logic     rst_n;
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_sel_t  sel;
  wb_cti_e  cti;
  wb_data_t dat_r;
  logic     ack;
  logic     err;
  logic     timer_irq;
  logic     sw_irq;

  // Stimulus and reference state
  logic [31:0] rng_q;
  wb_data_t    ram_model [`SOC_RAM_WORDS];
  logic        msip_model;
  string       cur_test;
  int          test_checks;
  int          test_errs;
  int          total_checks;
  int          total_errs;

  // Last completed transfer
  wb_data_t rsp_dat;
  logic     rsp_ack;
  logic     rsp_err;
  int       rsp_cycles;

  soc_bus_top DUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .wb_cyc_i   (cyc),
    .wb_stb_i   (stb),
    .wb_we_i    (we),
    .wb_adr_i   (adr),
    .wb_dat_i   (dat_w),
    .wb_sel_i   (sel),
    .wb_cti_i   (cti),
    .wb_dat_o   (dat_r),
    .wb_ack_o   (ack),
    .wb_err_o   (err),
    .timer_irq_o(timer_irq),
    .sw_irq_o   (sw_irq)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ======================================================================
  // Helpers
  // ======================================================================

  // Xorshift32
  function automatic logic [31:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 17);
    rng_q = rng_q ^ (rng_q << 5);
    return rng_q;
  endfunction

  function automatic wb_addr_t ram_addr(int idx);
    return {`SOC_RAM_BASE_NIB, 28'(idx * 4)};
  endfunction

  function automatic wb_addr_t clint_addr(logic [15:0] ofs);
    return {`SOC_CLINT_BASE_NIB, 12'h000, ofs};
  endfunction

  // Initial RAM content, spread over all address bits
  function automatic wb_data_t fill_word(int idx);
    return wb_data_t'(idx * 32'h9E3779B1) ^ 32'h5AC3_0F96;
  endfunction

  // Byte merge into the RAM model
  task automatic model_write(int idx, wb_data_t d, wb_sel_t s);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        ram_model[idx][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic report_error(string msg);
    test_errs++;
    total_errs++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  task automatic check_data(string what, wb_data_t exp, wb_data_t act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errs++;
      total_errs++;
      $display("CHECK FAILED %s/%s expected %08h actual %08h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    test_checks++;
    total_checks++;
    if (act !== exp) begin
      test_errs++;
      total_errs++;
      $display("CHECK FAILED %s/%s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cycles(string what, int exp, int act);
    test_checks++;
    total_checks++;
    if (act != exp) begin
      test_errs++;
      total_errs++;
      $display("CHECK FAILED %s/%s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic start_test(string name);
    cur_test    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errs);
  endtask

  // ======================================================================
  // Bus master
  // ======================================================================

  // Called 2 ns after a rising edge, returns at the same point after completion
  task automatic bus_xfer(logic w, wb_addr_t a, wb_data_t d, wb_sel_t s, wb_cti_e c);
    logic done;
    done  = 1'b0;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
    sel   = s;
    cti   = c;
    rsp_cycles = 0;
    // Response sampled mid-cycle
    while (!done) begin
      @(negedge clk);
      if (ack || err) begin
        done = 1'b1;
      end else if (rsp_cycles == ACK_LIMIT) begin
        done = 1'b1;
        report_error($sformatf("no ack or err from address %08h", a));
      end else begin
        rsp_cycles++;
      end
    end
    rsp_dat = dat_r;
    rsp_ack = ack;
    rsp_err = err;
    @(posedge clk);
    #2;
  endtask

  // Drop the request for one cycle
  task automatic release_bus();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    cti = CTI_CLASSIC;
    @(posedge clk);
    #2;
  endtask

  // ======================================================================
  // Tests
  // ======================================================================

  task automatic ram_rw_test();
    int          idx;
    logic [31:0] r;
    wb_data_t    d;
    int          written [$];
    start_test("ram_rw");
    for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
      bus_xfer(1'b1, ram_addr(i), fill_word(i), 4'hF, CTI_CLASSIC);
      release_bus();
      ram_model[i] = fill_word(i);
    end
    // Partial writes, random bytes
    for (int i = 0; i < 64; i++) begin
      idx = int'(next_rand() % `SOC_RAM_WORDS);
      d   = next_rand();
      r   = next_rand();
      bus_xfer(1'b1, ram_addr(idx), d, r[3:0], CTI_CLASSIC);
      release_bus();
      check_flag("write_ack", 1'b1, rsp_ack);
      model_write(idx, d, r[3:0]);
      written.push_back(idx);
    end
    foreach (written[i]) begin
      bus_xfer(1'b0, ram_addr(written[i]), '0, 4'hF, CTI_CLASSIC);
      release_bus();
      check_data("read", ram_model[written[i]], rsp_dat);
    end
    end_test();
  endtask

  task automatic latency_test();
    int       idx;
    wb_data_t d;
    start_test("ram_latency");
    for (int i = 0; i < 8; i++) begin
      idx = int'(next_rand() % `SOC_RAM_WORDS);
      d   = next_rand();
      bus_xfer(1'b1, ram_addr(idx), d, 4'hF, CTI_CLASSIC);
      release_bus();
      check_cycles("write_ack", 0, rsp_cycles);
      model_write(idx, d, 4'hF);
      idx = int'(next_rand() % `SOC_RAM_WORDS);
      bus_xfer(1'b0, ram_addr(idx), '0, 4'hF, CTI_CLASSIC);
      release_bus();
      check_cycles("read_ack", LAT, rsp_cycles);
      check_data("read", ram_model[idx], rsp_dat);
    end
    end_test();
  endtask

  task automatic burst_test();
    int      line;
    wb_cti_e c;
    start_test("ram_burst");
    for (int i = 0; i < 16; i++) begin
      line = int'(next_rand() % LINES);
      for (int b = 0; b < `SOC_LINE_WORDS; b++) begin
        c = (b == `SOC_LINE_WORDS - 1) ? CTI_EOB : CTI_INCR;
        bus_xfer(1'b0, ram_addr(line * `SOC_LINE_WORDS + b), '0, 4'hF, c);
        check_data("beat", ram_model[line * `SOC_LINE_WORDS + b], rsp_dat);
        // Fetch on the first beat, buffer after
        check_cycles("beat_ack", (b == 0) ? LAT : 0, rsp_cycles);
      end
      release_bus();
    end
    end_test();
  endtask

  task automatic msip_test();
    logic [31:0] r;
    wb_data_t    d;
    start_test("sw_irq");
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      d = next_rand();
      bus_xfer(1'b1, clint_addr(`SOC_CLINT_MSIP_OFS), d, r[7:4], CTI_CLASSIC);
      release_bus();
      check_cycles("clint_ack", 1, rsp_cycles);
      if (r[4]) begin
        msip_model = d[0];
      end
      check_flag("sw_irq", msip_model, sw_irq);
      bus_xfer(1'b0, clint_addr(`SOC_CLINT_MSIP_OFS), '0, 4'hF, CTI_CLASSIC);
      release_bus();
      check_data("msip_read", {31'b0, msip_model}, rsp_dat);
    end
    end_test();
  endtask

  task automatic timer_test();
    wb_data_t lo;
    wb_data_t prev;
    mtime_t   cmp;
    logic     fired;
    int       waited;
    start_test("timer_irq");
    for (int i = 0; i < 2; i++) begin
      bus_xfer(1'b0, clint_addr(`SOC_CLINT_MTIME_OFS), '0, 4'hF, CTI_CLASSIC);
      release_bus();
      lo = rsp_dat;
      bus_xfer(1'b0, clint_addr(`SOC_CLINT_MTIME_OFS + 16'd4), '0, 4'hF, CTI_CLASSIC);
      release_bus();
      cmp = {rsp_dat, lo} + 64'd50;
      bus_xfer(1'b1, clint_addr(`SOC_CLINT_MTIMECMP_OFS), cmp[31:0], 4'hF, CTI_CLASSIC);
      release_bus();
      bus_xfer(1'b1, clint_addr(`SOC_CLINT_MTIMECMP_OFS + 16'd4), cmp[63:32], 4'hF,
               CTI_CLASSIC);
      check_flag("irq_low", 1'b0, timer_irq);
      release_bus();
      // Rise expected within 60 cycles
      fired  = 1'b0;
      waited = 0;
      while (!fired && waited < 60) begin
        @(negedge clk);
        if (timer_irq) begin
          fired = 1'b1;
        end else begin
          waited++;
        end
      end
      @(posedge clk);
      #2;
      check_flag("irq_rise", 1'b1, fired);
      // mtime keeps counting up
      prev = lo;
      for (int k = 0; k < 4; k++) begin
        bus_xfer(1'b0, clint_addr(`SOC_CLINT_MTIME_OFS), '0, 4'hF, CTI_CLASSIC);
        release_bus();
        check_flag("mtime_incr", 1'b1, rsp_dat > prev);
        prev = rsp_dat;
      end
    end
    end_test();
  endtask

  task automatic unmapped_test();
    logic [31:0] r;
    logic [3:0]  nib;
    start_test("unmapped");
    for (int i = 0; i < 4; i++) begin
      r   = next_rand();
      nib = (i % 2 == 1) ? 4'h2 : 4'h0;
      bus_xfer(r[28], {nib, r[27:0]}, next_rand(), 4'hF, CTI_CLASSIC);
      release_bus();
      check_flag("err", 1'b1, rsp_err);
      check_flag("ack", 1'b0, rsp_ack);
      check_cycles("err_delay", 0, rsp_cycles);
    end
    end_test();
  endtask

  // ======================================================================
  // Sequence and watchdog
  // ======================================================================

  initial begin
    rng_q        = 32'd98359;
    msip_model   = 1'b0;
    total_checks = 0;
    total_errs   = 0;
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    sel   = '0;
    cti   = CTI_CLASSIC;
    // Reset over two rising edges
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    ram_rw_test();
    latency_test();
    burst_test();
    msip_test();
    timer_test();
    unmapped_test();
    $display("total: %0d checks, %0d errors", total_checks, total_errs);
    if (total_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/soc_pkg.sv
rtl/wb_if.sv
rtl/wb_interconnect.sv
rtl/wb_ram_slave.sv
rtl/wb_clint_slave.sv
rtl/soc_bus_top.sv
test/tb_soc_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f vlog.f --top-module tb_soc_bus -o tb_soc_bus \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_soc_bus > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
